// File: compile.f
common/rv32_pkg.sv
fetch/decoder.sv
fetch/fetch_unit.sv
hdl/inst_queue.sv
execute/regfile.sv
execute/alu.sv
execute/multiplier.sv
execute/execute_unit.sv
hdl/core_top.sv
bench/tb_core.sv

// File: Makefile
TOP := tb_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

// File: bench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import rv32_pkg::*;

    localparam int          NUM_ROWS       = 24;
    localparam int          TIMEOUT_CYCLES = NUM_ROWS * (8 + MUL_CYCLES + 4) + 50;
    localparam logic [31:0] NOP_INST       = 32'h0000_0013;

    logic            clk;
    logic            rst_n;
    logic            inst_resp;
    logic [XLEN-1:0] inst_rdata;
    logic            inst_read;
    logic [XLEN-1:0] inst_addr;
    retire_t         retire;

    // stimulus and expected values, one row per instruction
    logic [31:0] prog_mem [NUM_ROWS];
    logic [4:0]  exp_rd   [NUM_ROWS];
    logic [31:0] exp_data [NUM_ROWS];
    int          row_count;

    core_top i_core_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_resp_i  (inst_resp),
        .inst_rdata_i (inst_rdata),
        .inst_read_o  (inst_read),
        .inst_addr_o  (inst_addr),
        .retire_o     (retire)
    );

    function automatic logic [31:0] encode_itype(input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_utype(input logic [6:0] opc, input logic [4:0] rd,
                                                 input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input logic [31:0] inst, input logic [4:0] rd,
                           input logic [31:0] data);
        prog_mem[row_count] = inst;
        exp_rd[row_count]   = rd;
        exp_data[row_count] = data;
        row_count++;
    endtask

    task automatic load_program();
        row_count = 0;
        add_row(encode_itype(3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'h0000_0005);
        add_row(encode_itype(3'b000, 5'd2, 5'd0, 12'hFFD), 5'd2, 32'hFFFF_FFFD);
        // chain through the bypass
        add_row(encode_rtype(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0002);
        add_row(encode_rtype(7'h20, 3'b000, 5'd4, 5'd2, 5'd1), 5'd4, 32'hFFFF_FFF8);
        add_row(encode_rtype(7'h00, 3'b010, 5'd5, 5'd4, 5'd1), 5'd5, 32'h0000_0001);
        add_row(encode_rtype(7'h00, 3'b011, 5'd6, 5'd4, 5'd1), 5'd6, 32'h0000_0000);
        add_row(encode_itype(3'b101, 5'd7, 5'd4, 12'h402), 5'd7, 32'hFFFF_FFFE);
        add_row(encode_itype(3'b101, 5'd8, 5'd4, 12'h004), 5'd8, 32'h0FFF_FFFF);
        add_row(encode_utype(7'b0110111, 5'd9, 20'h12345), 5'd9, 32'h1234_5000);
        // auipc at pc 0x24
        add_row(encode_utype(7'b0010111, 5'd10, 20'h00001), 5'd10, 32'h0000_1024);
        add_row(encode_itype(3'b110, 5'd11, 5'd9, 12'h678), 5'd11, 32'h1234_5678);
        add_row(encode_itype(3'b100, 5'd12, 5'd11, 12'hFFF), 5'd12, 32'hEDCB_A987);
        add_row(encode_rtype(7'h00, 3'b111, 5'd13, 5'd12, 5'd11), 5'd13, 32'h0000_0000);
        add_row(encode_itype(3'b001, 5'd14, 5'd1, 12'd28), 5'd14, 32'h5000_0000);
        add_row(encode_itype(3'b010, 5'd15, 5'd2, 12'hFFE), 5'd15, 32'h0000_0001);
        add_row(encode_itype(3'b011, 5'd16, 5'd1, 12'hFFF), 5'd16, 32'h0000_0001);
        add_row(encode_utype(7'b0110111, 5'd17, 20'h80000), 5'd17, 32'h8000_0000);
        // multiplies on the most negative value and on -3
        add_row(encode_rtype(7'h01, 3'b000, 5'd18, 5'd17, 5'd2), 5'd18, 32'h8000_0000);
        add_row(encode_rtype(7'h01, 3'b001, 5'd19, 5'd17, 5'd2), 5'd19, 32'h0000_0001);
        add_row(encode_rtype(7'h01, 3'b010, 5'd20, 5'd2, 5'd17), 5'd20, 32'hFFFF_FFFE);
        add_row(encode_rtype(7'h01, 3'b011, 5'd21, 5'd2, 5'd2), 5'd21, 32'hFFFF_FFFA);
        // both operands come from the multiply still in writeback
        add_row(encode_rtype(7'h00, 3'b000, 5'd22, 5'd21, 5'd21), 5'd22, 32'hFFFF_FFF4);
        add_row(encode_rtype(7'h01, 3'b000, 5'd23, 5'd1, 5'd2), 5'd23, 32'hFFFF_FFF1);
        add_row(encode_itype(3'b000, 5'd0, 5'd1, 12'd7), 5'd0, 32'h0000_0000);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // answers each request after 0 to 7 idle cycles
    initial begin : memory_model
        logic [15:0] lfsr;
        logic [2:0]  delay;
        logic        pending;
        int          resp_count;
        int          idx;
        inst_resp  = 1'b0;
        inst_rdata = '0;
        lfsr       = 16'd80;
        delay      = '0;
        pending    = 1'b0;
        resp_count = 0;
        forever begin
            @(negedge clk);
            inst_resp = 1'b0;
            if (inst_read) begin
                if (!pending) begin
                    pending = 1'b1;
                    for (int b = 0; b < 3; b++) begin
                        lfsr  = lfsr_step(lfsr);
                        delay = {delay[1:0], lfsr[0]};
                    end
                end
                if (delay == 3'd0) begin
                    check_value("inst_addr_o", inst_addr, 32'(resp_count * 4));
                    idx        = int'(inst_addr[31:2]);
                    inst_rdata = (idx < NUM_ROWS) ? prog_mem[idx] : NOP_INST;
                    inst_resp  = 1'b1;
                    pending    = 1'b0;
                    resp_count++;
                end else begin
                    delay = delay - 3'd1;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles before all instructions retired", cycles);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin : main_sequence
        int row;
        rst_n = 1'b0;
        load_program();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("inst_read_o", 32'(inst_read), 32'd0);
        check_value("retire_o.valid", 32'(retire.valid), 32'd0);
        @(negedge clk);
        check_value("inst_read_o", 32'(inst_read), 32'd1);
        check_value("inst_addr_o", inst_addr, 32'd0);
        // one retire per cycle at most, compared in program order
        row = 0;
        while (row < NUM_ROWS) begin
            @(negedge clk);
            if (retire.valid) begin
                check_value("retire_o.rd", 32'(retire.rd), 32'(exp_rd[row]));
                check_value("retire_o.data", retire.data, exp_data[row]);
                row++;
            end
        end
        $display("all %0d table rows retired in order", NUM_ROWS);
        $display("RESULT: PASS");
        $finish;
    end

endmodule : tb_core

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      inst_resp_i,
    input  logic [rv32_pkg::XLEN-1:0] inst_rdata_i,
    output logic                      inst_read_o,
    output logic [rv32_pkg::XLEN-1:0] inst_addr_o,
    output rv32_pkg::retire_t         retire_o
);
    import rv32_pkg::*;

    decoded_inst_t push_entry;
    decoded_inst_t head_entry;
    logic          push;
    logic          pop;
    logic          credit;
    logic          head_valid;

    fetch_unit i_fetch_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_resp_i  (inst_resp_i),
        .inst_rdata_i (inst_rdata_i),
        .inst_read_o  (inst_read_o),
        .inst_addr_o  (inst_addr_o),
        .credit_i     (credit),
        .push_o       (push),
        .entry_o      (push_entry)
    );

    inst_queue i_inst_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .entry_i      (push_entry),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head_entry),
        .credit_o     (credit)
    );

    execute_unit i_execute_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .head_valid_i (head_valid),
        .head_i       (head_entry),
        .pop_o        (pop),
        .retire_o     (retire_o)
    );

endmodule : core_top

`default_nettype wire

// File: execute/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    head_valid_i,
    input  rv32_pkg::decoded_inst_t head_i,
    output logic                    pop_o,
    output rv32_pkg::retire_t       retire_o
);
    import rv32_pkg::*;

    retire_t               wb_q;
    retire_t               wb_d;
    logic [REG_ADDR_W-1:0] mul_rd_q;
    logic [REG_ADDR_W-1:0] dest_rd;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       fwd_a;
    logic [XLEN-1:0]       fwd_b;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       mul_result;
    logic                  is_mul;
    logic                  issue;
    logic                  mul_busy;
    logic                  mul_done;

    regfile i_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_q.valid),
        .waddr_i   (wb_q.rd),
        .wdata_i   (wb_q.data),
        .raddr_a_i (head_i.rs1),
        .raddr_b_i (head_i.rs2),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    // bypass the value being written back this cycle
    assign fwd_a = (wb_q.valid && wb_q.rd != '0 && wb_q.rd == head_i.rs1) ? wb_q.data : rs1_data;
    assign fwd_b = (wb_q.valid && wb_q.rd != '0 && wb_q.rd == head_i.rs2) ? wb_q.data : rs2_data;
    assign op_a  = head_i.src_a_pc  ? head_i.pc  : fwd_a;
    assign op_b  = head_i.src_b_imm ? head_i.imm : fwd_b;

    alu i_alu (
        .op_i     (head_i.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result)
    );

    multiplier i_multiplier (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (issue && is_mul),
        .op_i     (head_i.mul_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .busy_o   (mul_busy),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    // issue is held until the multiply result owns the writeback slot
    assign is_mul  = (head_i.wb_sel == wb_mul);
    assign issue   = head_valid_i && !mul_busy && !mul_done;
    assign pop_o   = issue;
    assign dest_rd = head_i.writes_rd ? head_i.rd : '0;

    always_comb begin : wb_select
        wb_d       = wb_q;
        wb_d.valid = 1'b0;
        if (mul_done) begin
            wb_d.valid = 1'b1;
            wb_d.rd    = mul_rd_q;
            wb_d.data  = mul_result;
        end else if (issue && !is_mul) begin
            wb_d.valid = 1'b1;
            wb_d.rd    = dest_rd;
            wb_d.data  = (head_i.wb_sel == wb_imm) ? head_i.imm : alu_result;
        end
        // x0 always retires zero
        if (wb_d.rd == '0) begin
            wb_d.data = '0;
        end
    end : wb_select

    always_ff @(posedge clk_i) begin
        if (issue && is_mul) begin
            mul_rd_q <= dest_rd;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_d;
        end
    end

    assign retire_o = wb_q;

    a_mul_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_o && is_mul |-> ##(MUL_CYCLES + 2) retire_o.valid)
        else $error("multiply did not retire on time");

endmodule : execute_unit

`default_nettype wire

// File: execute/multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module multiplier (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  rv32_pkg::mul_op_e         op_i,
    input  logic [rv32_pkg::XLEN-1:0] a_i,
    input  logic [rv32_pkg::XLEN-1:0] b_i,
    output logic                      busy_o,
    output logic                      done_o,
    output logic [rv32_pkg::XLEN-1:0] result_o
);
    import rv32_pkg::*;

    typedef enum logic {
        st_idle,
        st_busy
    } state_e;

    state_e               state_q;
    logic [MUL_CNT_W-1:0] cnt_q;
    logic                 done_q;
    mul_op_e              op_q;
    logic                 neg_q;
    logic [2*XLEN-1:0]    acc_q;
    logic [2*XLEN-1:0]    mcand_q;
    logic [XLEN-1:0]      mplier_q;
    logic                 a_neg;
    logic                 b_neg;
    logic [2*XLEN-1:0]    product;

    // which operands are signed depends on the variant
    assign a_neg = a_i[XLEN-1] && (op_i == mul_mulh || op_i == mul_mulhsu);
    assign b_neg = b_i[XLEN-1] && (op_i == mul_mulh);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start_i) begin
                        state_q <= st_busy;
                        cnt_q   <= '0;
                    end
                end
                st_busy: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == MUL_CNT_W'(MUL_CYCLES - 1)) begin
                        state_q <= st_idle;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // shift-add on magnitudes, one multiplier bit per cycle
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            op_q     <= op_i;
            neg_q    <= a_neg ^ b_neg;
            acc_q    <= '0;
            mcand_q  <= {{XLEN{1'b0}}, a_neg ? -a_i : a_i};
            mplier_q <= b_neg ? -b_i : b_i;
        end else if (state_q == st_busy) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product  = neg_q ? -acc_q : acc_q;
    assign result_o = (op_q == mul_mul) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
    assign busy_o   = (state_q == st_busy);
    assign done_o   = done_q;

    a_no_restart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> state_q == st_idle && !done_q)
        else $error("multiply started while one is in flight");

endmodule : multiplier

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv32_pkg::alu_op_e         op_i,
    input  logic [rv32_pkg::XLEN-1:0] a_i,
    input  logic [rv32_pkg::XLEN-1:0] b_i,
    output logic [rv32_pkg::XLEN-1:0] result_o
);
    import rv32_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin : alu_comb
        case (op_i)
            alu_add:  result_o = a_i + b_i;
            alu_sub:  result_o = a_i - b_i;
            alu_sll:  result_o = a_i << shamt;
            alu_slt:  result_o = XLEN'($signed(a_i) < $signed(b_i));
            alu_sltu: result_o = XLEN'(a_i < b_i);
            alu_xor:  result_o = a_i ^ b_i;
            alu_srl:  result_o = a_i >> shamt;
            // sign bit fills from the left
            alu_sra:  result_o = XLEN'($signed(a_i) >>> shamt);
            alu_or:   result_o = a_i | b_i;
            alu_and:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end : alu_comb

endmodule : alu

`default_nettype wire

// File: execute/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            we_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv32_pkg::XLEN-1:0]       wdata_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [rv32_pkg::XLEN-1:0]       rdata_a_o,
    output logic [rv32_pkg::XLEN-1:0]       rdata_b_o
);
    import rv32_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs_q [2**REG_ADDR_W-1:1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule : regfile

`default_nettype wire

// File: hdl/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    push_i,
    input  rv32_pkg::decoded_inst_t entry_i,
    input  logic                    pop_i,
    output logic                    head_valid_o,
    output rv32_pkg::decoded_inst_t head_o,
    output logic                    credit_o
);
    import rv32_pkg::*;

    decoded_inst_t          slots_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [CREDIT_W-1:0]    count_q;
    logic                   do_pop;

    assign head_valid_o = (count_q != '0);
    assign head_o       = slots_q[rd_ptr_q];
    assign do_pop       = pop_i && head_valid_o;
    // slot is freed in the pop cycle
    assign credit_o     = do_pop;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            slots_q[wr_ptr_q] <= entry_i;
        end
    end

    // pointers wrap on their own width
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CREDIT_W'(push_i) - CREDIT_W'(do_pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> count_q != CREDIT_W'(QUEUE_DEPTH))
        else $error("push into full queue");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> head_valid_o)
        else $error("pop from empty queue");

endmodule : inst_queue

`default_nettype wire

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      inst_resp_i,
    input  logic [rv32_pkg::XLEN-1:0] inst_rdata_i,
    output logic                      inst_read_o,
    output logic [rv32_pkg::XLEN-1:0] inst_addr_o,
    input  logic                      credit_i,
    output logic                      push_o,
    output rv32_pkg::decoded_inst_t   entry_o
);
    import rv32_pkg::*;

    logic [XLEN-1:0]     pc_q;
    logic [CREDIT_W-1:0] credit_q;
    logic [CREDIT_W-1:0] credit_d;
    logic                req_q;

    decoder i_decoder (
        .inst_i  (inst_rdata_i),
        .pc_i    (pc_q),
        .entry_o (entry_o)
    );

    // every response is pushed straight into the queue
    assign push_o      = req_q && inst_resp_i;
    assign inst_read_o = req_q;
    assign inst_addr_o = pc_q;
    assign credit_d    = credit_q + CREDIT_W'(credit_i) - CREDIT_W'(push_o);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q     <= '0;
            credit_q <= CREDIT_W'(QUEUE_DEPTH);
            req_q    <= 1'b0;
        end else begin
            credit_q <= credit_d;
            if (push_o) begin
                pc_q <= pc_q + XLEN'(PC_STEP);
            end
            // hold the request until answered, then reissue if a slot is free
            if (!req_q || inst_resp_i) begin
                req_q <= (credit_d != '0);
            end
        end
    end

    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_q <= CREDIT_W'(QUEUE_DEPTH))
        else $error("credit count above queue depth");

    a_push_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_o |-> credit_q != '0)
        else $error("push without credit");

endmodule : fetch_unit

`default_nettype wire

// File: fetch/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic [rv32_pkg::XLEN-1:0] inst_i,
    input  logic [rv32_pkg::XLEN-1:0] pc_i,
    output rv32_pkg::decoded_inst_t   entry_o
);
    import rv32_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    opcode_e    opcode;

    // funct3 to ALU op, alt picks sub or sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? alu_sub : alu_add;
            3'b001:  alu_sel = alu_sll;
            3'b010:  alu_sel = alu_slt;
            3'b011:  alu_sel = alu_sltu;
            3'b100:  alu_sel = alu_xor;
            3'b101:  alu_sel = alt ? alu_sra : alu_srl;
            3'b110:  alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
    endfunction

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign opcode = opcode_e'(inst_i[6:0]);

    always_comb begin : decode
        entry_o     = '0;
        entry_o.pc  = pc_i;
        entry_o.rd  = inst_i[11:7];
        entry_o.rs1 = inst_i[19:15];
        entry_o.rs2 = inst_i[24:20];
        case (opcode)
            op_imm: begin
                entry_o.imm       = {{20{inst_i[31]}}, inst_i[31:20]};
                entry_o.rs2       = '0;
                entry_o.src_b_imm = 1'b1;
                entry_o.writes_rd = 1'b1;
                // bit 30 only means srai here, addi uses it as immediate
                entry_o.alu_op    = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
            end
            op_reg: begin
                entry_o.writes_rd = 1'b1;
                if (funct7 == 7'b0000001) begin
                    entry_o.wb_sel    = wb_mul;
                    entry_o.mul_op    = mul_op_e'(funct3);
                    // div and rem are not executed
                    entry_o.writes_rd = !funct3[2];
                end else begin
                    entry_o.alu_op = alu_sel(funct3, funct7[5]);
                end
            end
            op_lui, op_auipc: begin
                entry_o.imm       = {inst_i[31:12], 12'h000};
                entry_o.rs1       = '0;
                entry_o.rs2       = '0;
                entry_o.writes_rd = 1'b1;
                entry_o.wb_sel    = (opcode == op_lui) ? wb_imm : wb_alu;
                entry_o.src_a_pc  = (opcode == op_auipc);
                entry_o.src_b_imm = 1'b1;
            end
            default: begin
                // unsupported, retires as a nop
                entry_o.rd  = '0;
                entry_o.rs1 = '0;
                entry_o.rs2 = '0;
            end
        endcase
    end : decode

endmodule : decoder

`default_nettype wire

// File: common/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CREDIT_W    = 3;
    localparam int MUL_CYCLES  = 32;
    localparam int MUL_CNT_W   = $clog2(MUL_CYCLES);
    localparam int PC_STEP     = 4;

    // only the opcodes this core executes
    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // encoded as funct3 of the M extension
    typedef enum logic [2:0] {
        mul_mul    = 3'b000,
        mul_mulh   = 3'b001,
        mul_mulhsu = 3'b010,
        mul_mulhu  = 3'b011
    } mul_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_imm,
        wb_mul
    } wb_sel_e;

    // control and data word of one decoded instruction
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic                  src_a_pc;
        logic                  src_b_imm;
        wb_sel_e               wb_sel;
        mul_op_e               mul_op;
        logic                  writes_rd;
    } decoded_inst_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage : rv32_pkg

`default_nettype wire
